/* hdl/rv_idu_pkg.sv */
/*
 Shared types for the RV32I decode stage.
 The instruction union covers the base 32-bit formats only, with no compressed words.
 alu_op is {sub_sra, funct3} for register and immediate ALU ops.
 */

package rv_idu_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam logic [3:0] ALU_ADD  = 4'b0000;  // also address generation
    localparam logic [3:0] ALU_SUB  = 4'b1000;  // branch compare
    localparam logic [3:0] ALU_PASS = 4'b1111;  // lui passes the immediate straight through

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_BJU = 2'd1,
        UNIT_LSU = 2'd2,
        UNIT_CSR = 2'd3
    } dec_unit_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_t;

    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_inst_u;

    typedef struct packed {
        dec_unit_e  unit;
        logic [3:0] alu_op;
        logic [2:0] funct3;
        logic       is_load;
        logic       is_store;
        logic       sub_sra;    // funct7 bit 5
    } dec_info_t;

    typedef struct packed {
        logic [XLEN-1:0] inst_addr;
        logic [31:0]     inst;
        logic            inst_valid;
        logic            illegal_inst;
        logic            reg_we;
        logic [4:0]      reg_waddr;
        logic [4:0]      reg1_raddr;
        logic [4:0]      reg2_raddr;
        logic            csr_we;
        logic [11:0]     csr_addr;
        logic [XLEN-1:0] dec_imm;
        dec_info_t       dec_info;
        logic            is_pred_branch;
        logic            inst_jump;
        logic            inst_branch;
        logic            inst_csr_type;
    } id_ex_t;

    typedef struct packed {
        logic flush;
        logic stall;
        logic stall_agu;
    } cu_bus_t;

endpackage

/* hdl/rv_inst_decoder.sv */
/*
 Combinational RV32I decoder, zero cycles.
 ECALL/EBREAK decode as illegal and fence passes as a no-op ALU op.
 Register indices are zeroed when the format does not use them.
 */

`timescale 1ns/1ps

module rv_inst_decoder import rv_idu_pkg::*; (
    input  rv_inst_u        inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            inst_valid_i,
    input  logic            is_pred_branch_i,
    output id_ex_t          dec_entry_o,
    output logic            use_rs1_o,
    output logic            use_rs2_o
);

    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [XLEN-1:0] imm;
    dec_info_t       info;
    logic            writes_rd;
    logic            illegal;
    logic            jump;
    logic            branch;
    logic            csr_type;
    logic            csr_wr;
    logic            ok;

    assign opc = inst_i.r.opcode;
    assign f3  = inst_i.r.funct3;

    always_comb begin
        imm         = '0;
        info        = '0;
        info.unit   = UNIT_ALU;
        info.alu_op = ALU_ADD;
        info.funct3 = f3;
        writes_rd   = 1'b0;
        use_rs1_o   = 1'b0;
        use_rs2_o   = 1'b0;
        illegal     = 1'b0;
        jump        = 1'b0;
        branch      = 1'b0;
        csr_type    = 1'b0;
        csr_wr      = 1'b0;
        case (opc)
            OPC_LUI, OPC_AUIPC: begin
                writes_rd   = 1'b1;
                imm         = {inst_i.u.imm_31_12, 12'b0};
                info.funct3 = '0;                       // bits belong to the immediate
                info.alu_op = (opc == OPC_LUI) ? ALU_PASS : ALU_ADD;
            end
            OPC_JAL: begin
                writes_rd   = 1'b1;
                jump        = 1'b1;
                info.unit   = UNIT_BJU;
                info.funct3 = '0;
                imm = {{11{inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
                       inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};
            end
            OPC_JALR: begin
                writes_rd = 1'b1;
                jump      = 1'b1;
                use_rs1_o = 1'b1;
                info.unit = UNIT_BJU;
                imm       = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
                illegal   = (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                branch      = 1'b1;
                use_rs1_o   = 1'b1;
                use_rs2_o   = 1'b1;
                info.unit   = UNIT_BJU;
                info.alu_op = ALU_SUB;
                imm = {{19{inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
                       inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
                illegal     = (f3[2:1] == 2'b01);       // funct3 2 and 3 unused
            end
            OPC_LOAD: begin
                writes_rd    = 1'b1;
                use_rs1_o    = 1'b1;
                info.unit    = UNIT_LSU;
                info.is_load = 1'b1;
                imm          = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
                illegal      = (f3 == 3'b011) || (f3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                use_rs1_o     = 1'b1;
                use_rs2_o     = 1'b1;
                info.unit     = UNIT_LSU;
                info.is_store = 1'b1;
                imm = {{20{inst_i.s.imm_11_5[6]}}, inst_i.s.imm_11_5, inst_i.s.imm_4_0};
                illegal       = (f3 > 3'b010);
            end
            OPC_OPIMM: begin
                writes_rd    = 1'b1;
                use_rs1_o    = 1'b1;
                imm          = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
                info.sub_sra = (f3 == 3'b101) && inst_i.r.funct7[5];  // srai only
                info.alu_op  = {info.sub_sra, f3};
            end
            OPC_OP: begin
                writes_rd    = 1'b1;
                use_rs1_o    = 1'b1;
                use_rs2_o    = 1'b1;
                info.sub_sra = inst_i.r.funct7[5];
                info.alu_op  = {info.sub_sra, f3};
                illegal = !((inst_i.r.funct7 == 7'h00) ||
                            ((inst_i.r.funct7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101)));
            end
            OPC_MISC_MEM: begin
                info.alu_op = ALU_ADD;                  // fence is a no-op here
            end
            OPC_SYSTEM: begin
                info.unit = UNIT_CSR;
                illegal   = (f3[1:0] == 2'b00);         // ecall/ebreak and funct3 4
                csr_type  = !illegal;
                writes_rd = !illegal;
                use_rs1_o = !illegal && !f3[2];
                imm       = f3[2] ? {27'b0, inst_i.i.rs1} : '0;  // zimm
                csr_wr    = csr_type && !(f3[1] && (inst_i.i.rs1 == 5'd0));
            end
            default: illegal = 1'b1;
        endcase
    end

    assign ok = inst_valid_i && !illegal;

    always_comb begin
        dec_entry_o                = '0;
        dec_entry_o.inst_addr      = inst_addr_i;
        dec_entry_o.inst           = inst_i;
        dec_entry_o.inst_valid     = inst_valid_i;
        dec_entry_o.illegal_inst   = illegal;
        dec_entry_o.reg_we         = ok && writes_rd && (inst_i.r.rd != 5'd0);
        dec_entry_o.reg_waddr      = writes_rd ? inst_i.r.rd : 5'd0;
        dec_entry_o.reg1_raddr     = use_rs1_o ? inst_i.r.rs1 : 5'd0;
        dec_entry_o.reg2_raddr     = use_rs2_o ? inst_i.r.rs2 : 5'd0;
        dec_entry_o.csr_we         = ok && csr_wr;
        dec_entry_o.csr_addr       = (opc == OPC_SYSTEM) ? inst_i.i.imm_11_0 : 12'd0;
        dec_entry_o.dec_imm        = imm;
        dec_entry_o.dec_info       = info;
        dec_entry_o.is_pred_branch = is_pred_branch_i;
        dec_entry_o.inst_jump      = jump;
        dec_entry_o.inst_branch    = branch;
        dec_entry_o.inst_csr_type  = csr_type;
    end

endmodule

/* hdl/rv_hazard_ctrl.sv */
/*
 Stall and flush control for the ID/EX register, fully combinational.
 Only load-use is resolved here. Other hazards are left to forwarding in execute.
 */

`timescale 1ns/1ps

module rv_hazard_ctrl import rv_idu_pkg::*; (
    input  logic    inst_valid_i,
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    input  logic    use_rs1_i,
    input  logic    use_rs2_i,
    input  id_ex_t  ex_entry_i,
    input  logic    redirect_i,
    input  logic    ex_stall_i,
    input  logic    agu_stall_i,
    output cu_bus_t cu_bus_o,
    output logic    fetch_hold_o
);

    logic ex_is_load;   // valid load in EX that writes a real register
    logic rs_match;
    logic load_use;
    logic any_stall;

    assign ex_is_load = ex_entry_i.inst_valid &&
                        ex_entry_i.dec_info.is_load &&
                        ex_entry_i.reg_we &&
                        (ex_entry_i.reg_waddr != 5'd0);

    assign rs_match = (use_rs1_i && (rs1_i == ex_entry_i.reg_waddr)) ||
                      (use_rs2_i && (rs2_i == ex_entry_i.reg_waddr));

    assign load_use  = ex_is_load && inst_valid_i && rs_match;
    assign any_stall = ex_stall_i || agu_stall_i;

    always_comb begin
        cu_bus_o.flush     = redirect_i || load_use;   // bubble into EX
        cu_bus_o.stall     = ex_stall_i;
        cu_bus_o.stall_agu = agu_stall_i;
    end

    // fetch must replay the word next cycle
    // a redirect discards it, a stall keeps the register frozen anyway
    assign fetch_hold_o = load_use && !redirect_i && !any_stall;

endmodule

/* hdl/idu_id_pipe.sv */
/*
 ID/EX pipeline register with load enable.
 Any stall bit freezes the entry and wins over flush.
 Flush loads a bubble whose address is RESET_ADDR, the same value as after reset.
 */

`timescale 1ns/1ps

module idu_id_pipe import rv_idu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  id_ex_t  dec_entry_i,
    input  cu_bus_t cu_bus_i,
    output id_ex_t  ex_entry_o
);

    id_ex_t bubble;
    id_ex_t entry_dnxt;
    id_ex_t entry_q;
    logic   update_en;

    always_comb begin
        bubble           = '0;
        bubble.inst_addr = RESET_ADDR;
    end

    assign update_en  = !(cu_bus_i.stall || cu_bus_i.stall_agu);  // hold under back-pressure
    assign entry_dnxt = cu_bus_i.flush ? bubble : dec_entry_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            entry_q <= bubble;
        end else if (update_en) begin
            entry_q <= entry_dnxt;
        end
    end

    assign ex_entry_o = entry_q;

endmodule

/* hdl/rv_idu_top.sv */
/*
 Decode stage top. One cycle from inst_i to ex_entry_o when not stalled.
 On fetch_hold_o the same instruction must be presented again next cycle.
 */

`timescale 1ns/1ps

module rv_idu_top import rv_idu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [31:0]     inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            inst_valid_i,
    input  logic            is_pred_branch_i,
    input  logic            redirect_i,
    input  logic            ex_stall_i,
    input  logic            agu_stall_i,
    output id_ex_t          ex_entry_o,
    output logic            fetch_hold_o
);

    rv_inst_u inst_word;    // same bits seen as format views
    id_ex_t   dec_entry;
    id_ex_t   ex_entry;
    cu_bus_t  cu_bus;
    logic     use_rs1;
    logic     use_rs2;

    assign inst_word = inst_i;

    rv_inst_decoder u_decoder (
        .inst_i           (inst_word),
        .inst_addr_i      (inst_addr_i),
        .inst_valid_i     (inst_valid_i),
        .is_pred_branch_i (is_pred_branch_i),
        .dec_entry_o      (dec_entry),
        .use_rs1_o        (use_rs1),
        .use_rs2_o        (use_rs2)
    );

    rv_hazard_ctrl u_hazard (
        .inst_valid_i (inst_valid_i),
        .rs1_i        (dec_entry.reg1_raddr),
        .rs2_i        (dec_entry.reg2_raddr),
        .use_rs1_i    (use_rs1),
        .use_rs2_i    (use_rs2),
        .ex_entry_i   (ex_entry),       // EX stage load for load-use
        .redirect_i   (redirect_i),
        .ex_stall_i   (ex_stall_i),
        .agu_stall_i  (agu_stall_i),
        .cu_bus_o     (cu_bus),
        .fetch_hold_o (fetch_hold_o)
    );

    idu_id_pipe #(
        .RESET_ADDR (RESET_ADDR)
    ) u_id_pipe (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_entry_i (dec_entry),
        .cu_bus_i    (cu_bus),
        .ex_entry_o  (ex_entry)
    );

    assign ex_entry_o = ex_entry;

endmodule

/* tests/rv_idu_model.svh */
/*
 Reference model of the decode stage, included inside the testbench module.
 Immediates are rebuilt from raw bit positions of the word.
 RESET_ADDR must be declared before the include.
 */

`ifndef RV_IDU_MODEL_SVH
`define RV_IDU_MODEL_SVH

// galois form with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
        n = n ^ 32'h8020_0003;
    return n;
endfunction

function automatic id_ex_t bubble_entry();
    id_ex_t b;
    b           = '0;
    b.inst_addr = RESET_ADDR;
    return b;
endfunction

function automatic id_ex_t decode_word(input logic [31:0] w, input logic [31:0] addr,
                                       input logic valid, input logic pred,
                                       output logic u1, output logic u2);
    id_ex_t     e;
    logic [2:0] f3;
    logic [31:0] imm_i;
    logic       wr;
    logic       bad;
    logic       csr_wr;
    f3     = w[14:12];
    imm_i  = {{20{w[31]}}, w[31:20]};
    e      = '0;
    wr     = 1'b0;
    bad    = 1'b0;
    csr_wr = 1'b0;
    u1     = 1'b0;
    u2     = 1'b0;
    e.dec_info.unit   = UNIT_ALU;
    e.dec_info.funct3 = f3;
    case (w[6:0])
        OPC_LUI, OPC_AUIPC: begin
            wr                = 1'b1;
            e.dec_imm         = {w[31:12], 12'h000};
            e.dec_info.funct3 = 3'd0;
            e.dec_info.alu_op = (w[6:0] == OPC_LUI) ? 4'hf : 4'h0;
        end
        OPC_JAL: begin
            wr                = 1'b1;
            e.inst_jump       = 1'b1;
            e.dec_info.unit   = UNIT_BJU;
            e.dec_info.funct3 = 3'd0;
            e.dec_imm         = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OPC_JALR: begin
            wr              = 1'b1;
            u1              = 1'b1;
            e.inst_jump     = 1'b1;
            e.dec_info.unit = UNIT_BJU;
            e.dec_imm       = imm_i;
            bad             = (f3 != 3'd0);
        end
        OPC_BRANCH: begin
            u1                = 1'b1;
            u2                = 1'b1;
            e.inst_branch     = 1'b1;
            e.dec_info.unit   = UNIT_BJU;
            e.dec_info.alu_op = 4'h8;              // subtract for compare
            e.dec_imm         = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            bad               = (f3 == 3'd2) || (f3 == 3'd3);
        end
        OPC_LOAD: begin
            wr                 = 1'b1;
            u1                 = 1'b1;
            e.dec_info.unit    = UNIT_LSU;
            e.dec_info.is_load = 1'b1;
            e.dec_imm          = imm_i;
            bad                = (f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7);
        end
        OPC_STORE: begin
            u1                  = 1'b1;
            u2                  = 1'b1;
            e.dec_info.unit     = UNIT_LSU;
            e.dec_info.is_store = 1'b1;
            e.dec_imm           = {{20{w[31]}}, w[31:25], w[11:7]};
            bad                 = (f3 > 3'd2);
        end
        OPC_OPIMM: begin
            wr                 = 1'b1;
            u1                 = 1'b1;
            e.dec_imm          = imm_i;
            e.dec_info.sub_sra = (f3 == 3'd5) && w[30];
            e.dec_info.alu_op  = {(f3 == 3'd5) && w[30], f3};
        end
        OPC_OP: begin
            wr                 = 1'b1;
            u1                 = 1'b1;
            u2                 = 1'b1;
            e.dec_info.sub_sra = w[30];
            e.dec_info.alu_op  = {w[30], f3};
            bad = !((w[31:25] == 7'h00) ||
                    ((w[31:25] == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
        end
        OPC_MISC_MEM: begin
            bad = 1'b0;                            // fence has no effect
        end
        OPC_SYSTEM: begin
            e.dec_info.unit = UNIT_CSR;
            e.csr_addr      = w[31:20];
            e.dec_imm       = f3[2] ? {27'd0, w[19:15]} : 32'd0;
            bad             = (f3 == 3'd0) || (f3 == 3'd4);
            if (!bad) begin
                e.inst_csr_type = 1'b1;
                wr              = 1'b1;
                u1              = !f3[2];
                csr_wr          = !(f3[1] && (w[19:15] == 5'd0));  // set/clear with x0
            end
        end
        default: bad = 1'b1;
    endcase
    e.inst_addr      = addr;
    e.inst           = w;
    e.inst_valid     = valid;
    e.illegal_inst   = bad;
    e.reg_we         = valid && !bad && wr && (w[11:7] != 5'd0);
    e.reg_waddr      = wr ? w[11:7] : 5'd0;
    e.reg1_raddr     = u1 ? w[19:15] : 5'd0;
    e.reg2_raddr     = u2 ? w[24:20] : 5'd0;
    e.csr_we         = valid && !bad && csr_wr;
    e.is_pred_branch = pred;
    return e;
endfunction

function automatic logic load_use_hazard(input id_ex_t ex, input id_ex_t dec,
                                         input logic u1, input logic u2);
    logic ex_load;
    ex_load = ex.inst_valid && ex.dec_info.is_load && ex.reg_we && (ex.reg_waddr != 5'd0);
    return ex_load && dec.inst_valid &&
           ((u1 && (dec.reg1_raddr == ex.reg_waddr)) ||
            (u2 && (dec.reg2_raddr == ex.reg_waddr)));
endfunction

`endif

/* tests/tb_rv_idu.sv */
/*
 Random testbench for rv_idu_top, compared every cycle against the included model.
 Inputs change on the rising edge and outputs are sampled on the falling edge.
 The LFSR seed is fixed and every run repeats the same stimulus.
 */

`timescale 1ns/1ps

module tb_rv_idu import rv_idu_pkg::*; ();

    localparam logic [31:0] RESET_ADDR     = 32'h0000_0200;
    localparam int          NUM_CYCLES     = 3000;
    localparam int          TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        inst_valid_i;
    logic        is_pred_branch_i;
    logic        redirect_i;
    logic        ex_stall_i;
    logic        agu_stall_i;
    id_ex_t      ex_entry_o;
    logic        fetch_hold_o;

    logic [31:0] lfsr_state;
    logic [4:0]  last_rd;       // load rd reused as a source to provoke load-use
    id_ex_t      exp_entry;
    int          errors;
    int          checks;
    logic        run_done;

    `include "rv_idu_model.svh"

    rv_idu_top #(
        .RESET_ADDR (RESET_ADDR)
    ) uut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .inst_i           (inst_i),
        .inst_addr_i      (inst_addr_i),
        .inst_valid_i     (inst_valid_i),
        .is_pred_branch_i (is_pred_branch_i),
        .redirect_i       (redirect_i),
        .ex_stall_i       (ex_stall_i),
        .agu_stall_i      (agu_stall_i),
        .ex_entry_o       (ex_entry_o),
        .fetch_hold_o     (fetch_hold_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin : reset_gen
        rst_n_i = 1'b0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [31:0] make_inst();
        logic [31:0] w;
        logic [31:0] r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        w  = take_bits(32);
        f3 = w[14:12];
        r  = take_bits(2);
        if (r[1:0] == 2'd0)
            w[19:15] = last_rd;
        r = take_bits(2);
        if (r[1:0] == 2'd0)
            w[24:20] = last_rd;
        r = take_bits(3);
        if (r[2:0] == 3'd0) begin
            r = take_bits(3);
            case (r[2:0])
                3'd0: begin
                    opc = OPC_JALR;
                    f3  = (f3 == 3'd0) ? 3'd1 : f3;
                end
                3'd1: begin
                    opc = OPC_BRANCH;
                    f3  = {2'b01, f3[0]};
                end
                3'd2: begin
                    opc = OPC_LOAD;
                    f3  = f3[2] ? {2'b11, f3[0]} : 3'd3;
                end
                3'd3: begin
                    opc = OPC_STORE;
                    f3  = f3[2] ? f3 : 3'd3;
                end
                3'd4: begin
                    opc   = OPC_OP;
                    w[25] = 1'b1;                   // odd funct7 is never base ISA
                end
                3'd5: begin
                    opc      = OPC_OP;
                    w[31:25] = 7'h20;
                    f3       = ((f3 == 3'd0) || (f3 == 3'd5)) ? f3 + 3'd1 : f3;
                end
                3'd6: begin
                    opc = OPC_SYSTEM;
                    f3  = {f3[0], 2'b00};           // ecall or funct3 4
                end
                default: opc = {w[6:2], 1'b0, w[0]};  // low bits never 2'b11
            endcase
        end else begin
            r = take_bits(4);
            case (r[3:0])
                4'd0: opc = OPC_LUI;
                4'd1: opc = OPC_AUIPC;
                4'd2: opc = OPC_JAL;
                4'd3: begin
                    opc = OPC_JALR;
                    f3  = 3'd0;
                end
                4'd4: begin
                    opc = OPC_BRANCH;
                    if (f3[2:1] == 2'b01)
                        f3[2] = 1'b1;
                end
                4'd5, 4'd6, 4'd7: begin
                    opc = OPC_LOAD;
                    if ((f3 == 3'd3) || (f3[2:1] == 2'b11))
                        f3 = 3'd2;
                end
                4'd8: begin
                    opc = OPC_STORE;
                    if (f3 > 3'd2)
                        f3 = {2'b00, f3[0]};
                end
                4'd9, 4'd10: opc = OPC_OPIMM;
                4'd11, 4'd12: begin
                    opc      = OPC_OP;
                    w[31:25] = (w[30] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
                end
                4'd13: opc = OPC_MISC_MEM;
                default: begin
                    opc = OPC_SYSTEM;
                    if (f3[1:0] == 2'b00)
                        f3[0] = 1'b1;
                end
            endcase
        end
        w[14:12] = f3;
        w[6:0]   = opc;
        return w;
    endfunction

    function automatic logic load_use_now(output id_ex_t dec);
        logic u1;
        logic u2;
        dec = decode_word(inst_i, inst_addr_i, inst_valid_i, is_pred_branch_i, u1, u2);
        return load_use_hazard(exp_entry, dec, u1, u2);
    endfunction

    function automatic logic hold_from(input logic lu);
        return lu && !redirect_i && !ex_stall_i && !agu_stall_i;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        id_ex_t dec;
        id_ex_t e;
        id_ex_t a;
        logic   lu;
        lu = load_use_now(dec);
        e  = exp_entry;
        a  = ex_entry_o;
        check_value("fetch_hold_o", 32'(hold_from(lu)), 32'(fetch_hold_o));
        check_value("inst_addr", e.inst_addr, a.inst_addr);
        check_value("inst", e.inst, a.inst);
        check_value("inst_valid", 32'(e.inst_valid), 32'(a.inst_valid));
        check_value("illegal_inst", 32'(e.illegal_inst), 32'(a.illegal_inst));
        check_value("reg_we", 32'(e.reg_we), 32'(a.reg_we));
        check_value("reg_waddr", 32'(e.reg_waddr), 32'(a.reg_waddr));
        check_value("reg1_raddr", 32'(e.reg1_raddr), 32'(a.reg1_raddr));
        check_value("reg2_raddr", 32'(e.reg2_raddr), 32'(a.reg2_raddr));
        check_value("csr_we", 32'(e.csr_we), 32'(a.csr_we));
        check_value("csr_addr", 32'(e.csr_addr), 32'(a.csr_addr));
        check_value("dec_imm", e.dec_imm, a.dec_imm);
        check_value("dec_info.unit", 32'(e.dec_info.unit), 32'(a.dec_info.unit));
        check_value("dec_info.alu_op", 32'(e.dec_info.alu_op), 32'(a.dec_info.alu_op));
        check_value("dec_info.funct3", 32'(e.dec_info.funct3), 32'(a.dec_info.funct3));
        check_value("dec_info.is_load", 32'(e.dec_info.is_load), 32'(a.dec_info.is_load));
        check_value("dec_info.is_store", 32'(e.dec_info.is_store), 32'(a.dec_info.is_store));
        check_value("dec_info.sub_sra", 32'(e.dec_info.sub_sra), 32'(a.dec_info.sub_sra));
        check_value("is_pred_branch", 32'(e.is_pred_branch), 32'(a.is_pred_branch));
        check_value("inst_jump", 32'(e.inst_jump), 32'(a.inst_jump));
        check_value("inst_branch", 32'(e.inst_branch), 32'(a.inst_branch));
        check_value("inst_csr_type", 32'(e.inst_csr_type), 32'(a.inst_csr_type));
    endtask

    // register rule applied to the inputs the DUT samples at this edge
    task automatic advance_model(output logic hold);
        id_ex_t dec;
        logic   lu;
        lu   = load_use_now(dec);
        hold = hold_from(lu);
        if (!ex_stall_i && !agu_stall_i) begin
            exp_entry = (redirect_i || lu) ? bubble_entry() : dec;
        end
    endtask

    task automatic drive_inputs(input logic replay);
        logic [31:0] w;
        logic [31:0] r;
        if (!replay) begin              // on replay the same word stays
            w = make_inst();
            inst_i <= w;
            r = take_bits(30);
            inst_addr_i <= {r[29:0], 2'b00};
            r = take_bits(3);
            inst_valid_i <= (r[2:0] != 3'd0);
            r = take_bits(1);
            is_pred_branch_i <= r[0];
            if (w[6:0] == OPC_LOAD)
                last_rd = w[11:7];
        end
        r = take_bits(4);
        redirect_i <= (r[3:0] == 4'd0);
        r = take_bits(3);
        ex_stall_i <= (r[2:0] == 3'd0);
        r = take_bits(4);
        agu_stall_i <= (r[3:0] == 4'd0);
    endtask

    initial begin : stimulus
        int   cnt;
        logic hold;
        errors           = 0;
        checks           = 0;
        run_done         = 1'b0;
        lfsr_state       = 32'd327;
        last_rd          = 5'd0;
        exp_entry        = bubble_entry();
        inst_i           = '0;
        inst_addr_i      = '0;
        inst_valid_i     = 1'b0;
        is_pred_branch_i = 1'b0;
        redirect_i       = 1'b0;
        ex_stall_i       = 1'b0;
        agu_stall_i      = 1'b0;
        hold             = 1'b0;
        cnt              = 0;
        while ((rst_n_i !== 1'b1) && (cnt < 64)) begin
            @(negedge clk);
            compare_outputs();          // bubble while in reset
            cnt++;
        end
        if (rst_n_i === 1'b1) begin
            for (int n = 0; n < NUM_CYCLES; n++) begin
                @(posedge clk);
                advance_model(hold);
                drive_inputs(hold);
                @(negedge clk);
                compare_outputs();
            end
        end else begin
            $display("reset was not released within 64 cycles");
            errors++;
        end
        run_done = 1'b1;
    end

    initial begin : report
        int waited;
        waited = 0;
        while (!run_done && (waited < TIMEOUT_CYCLES)) begin
            @(posedge clk);
            waited++;
        end
        if (!run_done) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Done: errors found");
        end else begin
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
        end
        $finish;
    end

endmodule

/* rv_idu.f */
+incdir+tests
hdl/rv_idu_pkg.sv
hdl/rv_inst_decoder.sv
hdl/rv_hazard_ctrl.sv
hdl/idu_id_pipe.sv
hdl/rv_idu_top.sv
tests/tb_rv_idu.sv

/* run_sim.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator and run it.
# Exits non-zero when the build or the run fails, or when the pass line is missing.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_idu.f --top-module tb_rv_idu -o sim_tb_rv_idu
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb_rv_idu)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
